// ==== design/rtc_access_cfg.svh ====
`ifndef RTC_ACCESS_CFG_SVH
`define RTC_ACCESS_CFG_SVH

// Entries between sequencer and bus engine
`define RTC_QUEUE_DEPTH 4

// Control register and its power-up value
`define RTC_REG_CTRL 8'h00
`define RTC_INIT_VALUE 8'h10

// Seconds, then minutes and hours
`define RTC_REG_TIME_BASE 8'h21

// Day, then month and year
`define RTC_REG_DATE_BASE 8'h24

// Three stopwatch registers from here up
`define RTC_REG_CHRONO_BASE 8'h41

`endif

// ==== design/rtc_access_pkg.sv ====
`default_nettype none

package rtc_access_pkg;

    typedef logic [7:0] rtc_addr_t;
    typedef logic [7:0] rtc_byte_t;

    // Three BCD bytes, low byte first (sec/min/hour or day/month/year)
    typedef logic [23:0] rtc_field3_t;

    typedef enum logic [2:0] {
        TASK_INIT,
        TASK_READ_TIME,
        TASK_SET_TIME,
        TASK_SET_DATE,
        TASK_CLEAR_CHRONO
    } rtc_task_e;

    // One queued register access
    typedef struct packed {
        logic      write;
        rtc_addr_t addr;
        rtc_byte_t wdata;
    } rtc_access_t;

    // Outbound bus
    typedef struct packed {
        logic      req;
        logic      write;
        rtc_addr_t addr;
        rtc_byte_t wdata;
    } rtc_bus_req_t;

    // Inbound bus
    typedef struct packed {
        logic      ack;
        rtc_byte_t rdata;
    } rtc_bus_rsp_t;

    typedef struct packed {
        rtc_addr_t addr;
        rtc_byte_t data;
    } rtc_rd_result_t;

endpackage

`default_nettype wire

// ==== design/rtc_task_select.sv ====
`timescale 1ns/100ps
`default_nettype none

// panel_req bit map: [3] read time, [2] set time, [1] set date, [0] clear chrono
module rtc_task_select import rtc_access_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] panel_req,
    output logic       task_req,
    output rtc_task_e  task_id,
    input  logic       task_ack
);

    typedef enum logic {
        SEL_IDLE,
        SEL_REQ
    } sel_state_e;

    sel_state_e state;
    logic       init_pending;
    rtc_task_e  next_id;

    // Init first, then lowest-numbered active line
    always_comb begin
        next_id = TASK_READ_TIME;
        if (init_pending) begin
            next_id = TASK_INIT;
        end else if (panel_req[0]) begin
            next_id = TASK_CLEAR_CHRONO;
        end else if (panel_req[1]) begin
            next_id = TASK_SET_DATE;
        end else if (panel_req[2]) begin
            next_id = TASK_SET_TIME;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= SEL_IDLE;
            task_req     <= 1'b0;
            task_id      <= TASK_INIT;
            init_pending <= 1'b1;
        end else begin
            case (state)
                SEL_IDLE: begin
                    // previous ack must be gone before a new request
                    if (!task_ack && (init_pending || (|panel_req))) begin
                        task_id  <= next_id;
                        task_req <= 1'b1;
                        state    <= SEL_REQ;
                    end
                end
                SEL_REQ: begin
                    if (task_ack) begin
                        task_req     <= 1'b0;
                        init_pending <= 1'b0;
                        state        <= SEL_IDLE;
                    end
                end
            endcase
        end
    end

    // Sequencer relies on a steady task id for the whole handshake
    a_task_id_stable: assert property (@(posedge clk) disable iff (rst)
        task_req |=> (!task_req || $stable(task_id)))
        else $error("task_id changed while task_req was high");

endmodule

`default_nettype wire

// ==== design/rtc_task_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rtc_access_cfg.svh"

module rtc_task_sequencer import rtc_access_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        task_req,
    input  rtc_task_e   task_id,
    output logic        task_ack,
    input  rtc_field3_t set_value,
    output logic        push,
    output rtc_access_t push_data,
    input  logic        full
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_EMIT,
        SEQ_ACK
    } seq_state_e;

    seq_state_e  state;
    rtc_task_e   cur_task;
    rtc_field3_t value_q;
    logic [1:0]  step;
    logic [1:0]  last_step;
    rtc_addr_t   step_addr;
    rtc_byte_t   value_byte;

    //////////////////////////////////////////////////
    // Access list of the current task
    //////////////////////////////////////////////////

    // Init is a single access, every other task three
    assign last_step = (cur_task == TASK_INIT) ? 2'd0 : 2'd2;
    assign step_addr = rtc_addr_t'(step);

    always_comb begin
        case (step)
            2'd0:    value_byte = value_q[7:0];
            2'd1:    value_byte = value_q[15:8];
            default: value_byte = value_q[23:16];
        endcase
    end

    always_comb begin
        push_data = '0;
        case (cur_task)
            TASK_INIT: begin
                push_data.write = 1'b1;
                push_data.addr  = `RTC_REG_CTRL;
                push_data.wdata = `RTC_INIT_VALUE;
            end
            TASK_READ_TIME: begin
                push_data.addr  = `RTC_REG_TIME_BASE + step_addr;
            end
            TASK_SET_TIME: begin
                push_data.write = 1'b1;
                push_data.addr  = `RTC_REG_TIME_BASE + step_addr;
                push_data.wdata = value_byte;
            end
            TASK_SET_DATE: begin
                push_data.write = 1'b1;
                push_data.addr  = `RTC_REG_DATE_BASE + step_addr;
                push_data.wdata = value_byte;
            end
            TASK_CLEAR_CHRONO: begin
                // Zero data, already set by the default
                push_data.write = 1'b1;
                push_data.addr  = `RTC_REG_CHRONO_BASE + step_addr;
            end
            default: push_data = '0;
        endcase
    end

    // Entry stays on push_data while the queue is full
    assign push = (state == SEQ_EMIT) && !full;

    //////////////////////////////////////////////////
    // Task handshake and step counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            task_ack <= 1'b0;
            step     <= 2'd0;
            cur_task <= TASK_INIT;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (task_req) begin
                        cur_task <= task_id;
                        value_q  <= set_value;
                        step     <= 2'd0;
                        state    <= SEQ_EMIT;
                    end
                end
                SEQ_EMIT: begin
                    if (push) begin
                        if (step == last_step) begin
                            task_ack <= 1'b1;
                            state    <= SEQ_ACK;
                        end else begin
                            step <= step + 2'd1;
                        end
                    end
                end
                SEQ_ACK: begin
                    if (!task_req) begin
                        task_ack <= 1'b0;
                        state    <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rtc_access_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rtc_access_cfg.svh"

// DEPTH must be a power of two of at least 2
module rtc_access_queue import rtc_access_pkg::*; #(
    parameter int DEPTH = `RTC_QUEUE_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  rtc_access_t push_data,
    output logic        full,
    input  logic        pop,
    output rtc_access_t head,
    output logic        empty
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    rtc_access_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (AW + 1)'(1);
                2'b01:   count <= count - (AW + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into a full access queue");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop from an empty access queue");

endmodule

`default_nettype wire

// ==== design/rtc_bus_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtc_bus_engine import rtc_access_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           empty,
    input  rtc_access_t    head,
    output logic           pop,
    output rtc_bus_req_t   bus_req,
    input  rtc_bus_rsp_t   bus_rsp,
    output logic           rd_valid,
    output rtc_rd_result_t rd_result,
    output logic           idle
);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_REQ,
        ENG_RELEASE
    } eng_state_e;

    eng_state_e  state;
    logic        req_q;
    rtc_access_t cur_q;

    // Pop on the way out of idle, req follows a cycle later
    assign pop  = (state == ENG_IDLE) && !empty;
    assign idle = (state == ENG_IDLE);

    assign bus_req.req   = req_q;
    assign bus_req.write = cur_q.write;
    assign bus_req.addr  = cur_q.addr;
    assign bus_req.wdata = cur_q.wdata;

    //////////////////////////////////////////////////
    // Four-phase req/ack cycle
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ENG_IDLE;
            req_q    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (!empty) begin
                        req_q <= 1'b1;
                        state <= ENG_REQ;
                    end
                end
                ENG_REQ: begin
                    if (bus_rsp.ack) begin
                        req_q    <= 1'b0;
                        rd_valid <= !cur_q.write;
                        state    <= ENG_RELEASE;
                    end
                end
                ENG_RELEASE: begin
                    // Access complete once ack falls
                    if (!bus_rsp.ack) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Access fields and read capture
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_q <= head;
        end
        if ((state == ENG_REQ) && bus_rsp.ack) begin
            rd_result.addr <= cur_q.addr;
            rd_result.data <= bus_rsp.rdata;
        end
    end

    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_req.req && !bus_rsp.ack) |=> $stable(bus_req))
        else $error("bus request changed before ack");

endmodule

`default_nettype wire

// ==== design/rtc_access_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rtc_access_cfg.svh"

module rtc_access_top import rtc_access_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic [3:0]     panel_req,
    input  rtc_field3_t    set_value,
    output rtc_bus_req_t   bus_req,
    input  rtc_bus_rsp_t   bus_rsp,
    output logic           rd_valid,
    output rtc_rd_result_t rd_result,
    output logic           busy
);

    logic        task_req;
    rtc_task_e   task_id;
    logic        task_ack;
    logic        push;
    rtc_access_t push_data;
    logic        full;
    logic        pop;
    rtc_access_t head;
    logic        empty;
    logic        eng_idle;

    //////////////////////////////////////////////////
    // Task side
    //////////////////////////////////////////////////

    rtc_task_select select_i (
        .clk       (clk),
        .rst       (rst),
        .panel_req (panel_req),
        .task_req  (task_req),
        .task_id   (task_id),
        .task_ack  (task_ack)
    );

    rtc_task_sequencer sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .task_req  (task_req),
        .task_id   (task_id),
        .task_ack  (task_ack),
        .set_value (set_value),
        .push      (push),
        .push_data (push_data),
        .full      (full)
    );

    //////////////////////////////////////////////////
    // Access side
    //////////////////////////////////////////////////

    rtc_access_queue #(
        .DEPTH (`RTC_QUEUE_DEPTH)
    ) queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .head      (head),
        .empty     (empty)
    );

    rtc_bus_engine engine_i (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .rd_valid  (rd_valid),
        .rd_result (rd_result),
        .idle      (eng_idle)
    );

    // Nothing queued, nothing on the bus, no task in handshake
    assign busy = !(eng_idle && empty && !task_req);

endmodule

`default_nettype wire

// ==== bench/rtc_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtc_model import rtc_access_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   ack_delay,
    input  rtc_bus_req_t bus_req,
    output rtc_bus_rsp_t bus_rsp
);

    localparam int LOG_DEPTH = 64;

    rtc_byte_t   regs [256];
    logic [7:0]  wait_cnt;

    // Completed accesses, a read entry carries the byte returned
    rtc_access_t log_mem [LOG_DEPTH];
    int          log_count;

    always @(posedge clk) begin
        if (rst) begin
            bus_rsp   <= '0;
            wait_cnt  <= '0;
            log_count <= 0;
            for (int i = 0; i < 256; i++) begin
                regs[i] <= rtc_byte_t'(i) ^ 8'hc3;
            end
        end else if (bus_req.req && !bus_rsp.ack) begin
            if (wait_cnt >= ack_delay) begin
                bus_rsp.ack   <= 1'b1;
                bus_rsp.rdata <= regs[bus_req.addr];
                if (bus_req.write) begin
                    regs[bus_req.addr] <= bus_req.wdata;
                end
                if (log_count < LOG_DEPTH) begin
                    log_mem[log_count] <= {bus_req.write, bus_req.addr,
                        bus_req.write ? bus_req.wdata : regs[bus_req.addr]};
                end
                log_count <= log_count + 1;
                wait_cnt  <= '0;
            end else begin
                wait_cnt <= wait_cnt + 8'd1;
            end
        end else if (!bus_req.req && bus_rsp.ack) begin
            // Release phase of the handshake
            bus_rsp.ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/rtc_access_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rtc_access_cfg.svh"

module rtc_access_tb import rtc_access_pkg::*; ();

    localparam int NUM_ROWS   = 6;
    localparam int MAX_CYCLES = NUM_ROWS * 200;

    // One stimulus row
    // Bit k of wr_mask holds the write flag of access k
    typedef struct packed {
        logic [3:0]  panel;
        rtc_field3_t set_value;
        logic [7:0]  ack_delay;
        logic [3:0]  exp_count;
        rtc_addr_t   first_addr;
        logic [5:0]  wr_mask;
        rtc_field3_t exp_data;
    } row_t;

    logic           clk;
    logic           rst;
    logic [3:0]     panel_req;
    rtc_field3_t    set_value;
    rtc_bus_req_t   bus_req;
    rtc_bus_rsp_t   bus_rsp;
    logic           rd_valid;
    rtc_rd_result_t rd_result;
    logic           busy;
    logic [7:0]     ack_delay;

    row_t           rows [NUM_ROWS];
    string          row_name [NUM_ROWS];
    rtc_rd_result_t rd_log [64];
    int             rd_count = 0;
    int             log_start;
    int             rd_start;
    int             err_total = 0;
    int             bad_rows = 0;
    int             cycle_count = 0;
    int             seed = 32'hb7f9_92f6;

    rtc_access_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .panel_req (panel_req),
        .set_value (set_value),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .rd_valid  (rd_valid),
        .rd_result (rd_result),
        .busy      (busy)
    );

    rtc_model chip_i (
        .clk       (clk),
        .rst       (rst),
        .ack_delay (ack_delay),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // Collect read results on the falling edge
    always @(negedge clk) begin
        if (!rst && rd_valid && rd_count < 64) begin
            rd_log[rd_count] = rd_result;
            rd_count = rd_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    function automatic row_t make_row(input logic [3:0] panel, input rtc_field3_t value,
                                      input logic [7:0] delay, input logic [3:0] count,
                                      input rtc_addr_t first, input logic [5:0] mask,
                                      input rtc_field3_t data);
        row_t row;
        row.panel      = panel;
        row.set_value  = value;
        row.ack_delay  = delay;
        row.exp_count  = count;
        row.first_addr = first;
        row.wr_mask    = mask;
        row.exp_data   = data;
        return row;
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        rtc_field3_t time_val;
        rtc_field3_t date_val;
        rtc_field3_t chrono_val;
        rtc_field3_t both_val;
        rnd        = $random(seed);
        time_val   = rnd[23:0];
        rnd        = $random(seed);
        date_val   = rnd[23:0];
        rnd        = $random(seed);
        chrono_val = rnd[23:0];
        rnd        = $random(seed);
        both_val   = rnd[23:0];
        rows[0] = make_row(4'b0000, 24'h0, 8'd1, 4'd1, `RTC_REG_CTRL, 6'b000001,
                           {16'h0, `RTC_INIT_VALUE});
        rows[1] = make_row(4'b0100, time_val, 8'd2, 4'd3, `RTC_REG_TIME_BASE, 6'b000111,
                           time_val);
        rows[2] = make_row(4'b0010, date_val, 8'd1, 4'd3, `RTC_REG_DATE_BASE, 6'b000111,
                           date_val);
        // set_value has no effect on the stopwatch clear
        rows[3] = make_row(4'b0001, chrono_val, 8'd0, 4'd3, `RTC_REG_CHRONO_BASE, 6'b000111,
                           24'h0);
        rows[4] = make_row(4'b1000, 24'h0, 8'd3, 4'd3, `RTC_REG_TIME_BASE, 6'b000000,
                           time_val);
        // Set time first, then read time returns the same bytes
        rows[5] = make_row(4'b1100, both_val, 8'd6, 4'd6, `RTC_REG_TIME_BASE, 6'b000111,
                           both_val);
        row_name[0] = "init";
        row_name[1] = "set time";
        row_name[2] = "set date";
        row_name[3] = "clear chrono";
        row_name[4] = "read time";
        row_name[5] = "set and read, slow ack";
    endtask

    //////////////////////////////////////////////////
    // Apply and check one row
    //////////////////////////////////////////////////

    task automatic run_row(input int r);
        logic [3:0] remaining;
        logic       prev_req;
        logic       seen_busy;
        logic       done;
        remaining = rows[r].panel;
        prev_req  = 1'b0;
        seen_busy = 1'b0;
        done      = 1'b0;
        log_start = chip_i.log_count;
        rd_start  = rd_count;
        ack_delay = rows[r].ack_delay;
        set_value = rows[r].set_value;
        panel_req = remaining;
        while (!done) begin
            @(posedge clk);
            #1;
            // Each task start serves the lowest pending line
            if (dut_i.task_req && !prev_req) begin
                remaining = remaining & (remaining - 4'd1);
                panel_req = remaining;
            end
            prev_req = dut_i.task_req;
            if (busy) begin
                seen_busy = 1'b1;
            end else if (seen_busy && remaining == 4'd0) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic check_row(input int r);
        rtc_access_t    entry;
        rtc_rd_result_t res;
        rtc_addr_t      exp_addr;
        rtc_byte_t      exp_byte;
        logic           exp_write;
        int             n_acc;
        int             n_rd;
        int             errs;
        errs  = 0;
        n_rd  = 0;
        n_acc = chip_i.log_count - log_start;
        if (n_acc != int'(rows[r].exp_count)) begin
            $display("[FAIL] row %0d access count: got %h expected %h",
                     r, n_acc, rows[r].exp_count);
            errs++;
        end
        for (int k = 0; k < int'(rows[r].exp_count) && k < n_acc; k++) begin
            entry     = chip_i.log_mem[log_start + k];
            exp_addr  = rows[r].first_addr + rtc_addr_t'(k % 3);
            exp_byte  = rows[r].exp_data[8*(k % 3) +: 8];
            exp_write = rows[r].wr_mask[k];
            if (entry.write != exp_write) begin
                $display("[FAIL] row %0d access %0d bus_req.write: got %h expected %h",
                         r, k, entry.write, exp_write);
                errs++;
            end
            if (entry.addr != exp_addr) begin
                $display("[FAIL] row %0d access %0d bus_req.addr: got %h expected %h",
                         r, k, entry.addr, exp_addr);
                errs++;
            end
            if (entry.wdata != exp_byte) begin
                $display("[FAIL] row %0d access %0d %s: got %h expected %h",
                         r, k, entry.write ? "bus_req.wdata" : "bus_rsp.rdata",
                         entry.wdata, exp_byte);
                errs++;
            end
            if (!exp_write) begin
                if (rd_start + n_rd >= rd_count) begin
                    $display("Row %0d: no rd_valid pulse for access %0d", r, k);
                    errs++;
                end else begin
                    res = rd_log[rd_start + n_rd];
                    if (res.addr != exp_addr) begin
                        $display("[FAIL] row %0d read %0d rd_result.addr: got %h expected %h",
                                 r, n_rd, res.addr, exp_addr);
                        errs++;
                    end
                    if (res.data != exp_byte) begin
                        $display("[FAIL] row %0d read %0d rd_result.data: got %h expected %h",
                                 r, n_rd, res.data, exp_byte);
                        errs++;
                    end
                end
                n_rd++;
            end
        end
        if (rd_count - rd_start != n_rd) begin
            $display("Row %0d: %0d rd_valid pulses where %0d reads were expected",
                     r, rd_count - rd_start, n_rd);
            errs++;
        end
        err_total = err_total + errs;
        if (errs == 0) begin
            $display("Row %0d %s: ok", r, row_name[r]);
        end else begin
            bad_rows++;
            $display("Row %0d %s: %0d errors", r, row_name[r], errs);
        end
    endtask

    initial begin
        rst       = 1'b1;
        panel_req = 4'd0;
        set_value = '0;
        ack_delay = 8'd1;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Row 0 only watches the init task that follows reset
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
            check_row(r);
        end
        $display("Rows run: %0d, rows with errors: %0d, failed checks: %0d",
                 NUM_ROWS, bad_rows, err_total);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtc_access.f ====
+incdir+design
design/rtc_access_pkg.sv
design/rtc_task_select.sv
design/rtc_task_sequencer.sv
design/rtc_access_queue.sv
design/rtc_bus_engine.sv
design/rtc_access_top.sv
bench/rtc_model.sv
bench/rtc_access_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RTC access controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rtc_access_tb -Mdir obj_dir -f rtc_access.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrtc_access_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
